//--- sources.f
src/isa_pkg.sv
src/rob_pkg.sv
src/gl_pointers.sv
src/graduation_list.sv
src/commit_ctrl.sv
src/commit_top.sv
testbench/commit_assertions.sv
testbench/commit_tb.sv

//--- src/commit_ctrl.sv
// Commit controller: drains the head, reports exceptions
// and holds commit until the front end acknowledges the redirect
`timescale 1ns/1ns

module commit_ctrl (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             head_ready_i,
    input  rob_pkg::commit_t commit_i,        // Registered commit from the list
    input  logic             redirect_ack_i,
    output logic             read_head_o,
    output logic             flush_all_o,
    output logic             stall_o,
    output rob_pkg::commit_t exc_o
);

    typedef enum logic {
        RUN,
        WAIT_REDIRECT
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   exc_commit;

    // An exception is taken when its instruction reaches commit
    assign exc_commit = (state_q == RUN) && commit_i.valid && commit_i.exc_valid;

    // Stop reading at once so nothing younger commits
    assign read_head_o = (state_q == RUN) && head_ready_i && !exc_commit;
    assign flush_all_o = exc_commit;
    assign stall_o     = (state_q == WAIT_REDIRECT);

    always_comb begin
        exc_o       = commit_i;
        exc_o.valid = exc_commit;  // One cycle pulse
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            RUN: begin
                if (exc_commit) begin
                    state_d = WAIT_REDIRECT;
                end
            end
            WAIT_REDIRECT: begin
                if (redirect_ack_i) begin
                    state_d = RUN;  // Front end now fetches the handler
                end
            end
            default: state_d = RUN;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= RUN;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

//--- src/commit_top.sv
// Completion stage top: graduation list with its pointers
// and the commit controller
`timescale 1ns/1ns

module commit_top #(
    parameter int NUM_ENTRIES = 16,
    parameter int NUM_WB      = 3
) (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  rob_pkg::gl_entry_t             dispatch_i,
    output logic [$clog2(NUM_ENTRIES)-1:0] alloc_idx_o,
    input  rob_pkg::gl_wb_t [NUM_WB-1:0]   wb_i,
    input  logic [NUM_WB-1:0]              wb_en_i,
    input  logic                           flush_i,      // Mispredict flush
    input  logic [$clog2(NUM_ENTRIES)-1:0] flush_idx_i,
    output rob_pkg::commit_t               commit_o,
    output rob_pkg::commit_t               exc_o,
    input  logic                           redirect_ack_i,
    output logic                           full_o,
    output logic                           empty_o
);

    logic head_ready;
    logic read_head;
    logic flush_all;
    logic stall;

    graduation_list #(
        .NUM_ENTRIES (NUM_ENTRIES),
        .NUM_WB      (NUM_WB)
    ) i_list (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .dispatch_i   (dispatch_i),
        .wb_i         (wb_i),
        .wb_en_i      (wb_en_i),
        .flush_i      (flush_i),
        .flush_idx_i  (flush_idx_i),
        .flush_all_i  (flush_all),
        .read_head_i  (read_head),
        .stall_i      (stall),
        .alloc_idx_o  (alloc_idx_o),
        .head_ready_o (head_ready),
        .commit_o     (commit_o),
        .full_o       (full_o),
        .empty_o      (empty_o)
    );

    commit_ctrl i_ctrl (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .head_ready_i   (head_ready),
        .commit_i       (commit_o),
        .redirect_ack_i (redirect_ack_i),
        .read_head_o    (read_head),
        .flush_all_o    (flush_all),
        .stall_o        (stall),
        .exc_o          (exc_o)
    );

endmodule

//--- src/gl_pointers.sv
// Head, tail and occupancy of the graduation list
// with recovery after a mispredict flush or a full flush
`timescale 1ns/1ns

module gl_pointers #(
    parameter int NUM_ENTRIES = 16
) (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  logic                           write_en_i,
    input  logic                           read_en_i,
    input  logic                           flush_i,      // Drop entries younger than flush_idx_i
    input  logic [$clog2(NUM_ENTRIES)-1:0] flush_idx_i,  // Last entry kept
    input  logic                           flush_all_i,
    output logic [$clog2(NUM_ENTRIES)-1:0] head_o,
    output logic [$clog2(NUM_ENTRIES)-1:0] tail_o,
    output logic [$clog2(NUM_ENTRIES):0]   count_o
);

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    logic [IDX_W-1:0] head_q;
    logic [IDX_W-1:0] tail_q;
    logic [IDX_W:0]   count_q;  // One bit wider than the indices
    logic [IDX_W-1:0] head_nxt;
    logic [IDX_W-1:0] flush_tail;

    // Index arithmetic wraps by itself since NUM_ENTRIES is a power of two
    assign head_nxt   = head_q + IDX_W'(read_en_i);
    assign flush_tail = flush_idx_i + IDX_W'(1);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_all_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i && (count_q != '0)) begin
            // Younger entries vanish, occupancy is the distance head to new tail
            head_q  <= head_nxt;
            tail_q  <= flush_tail;
            count_q <= {1'b0, flush_tail - head_nxt};
        end else begin
            head_q  <= head_nxt;
            tail_q  <= tail_q + IDX_W'(write_en_i);
            count_q <= count_q + (IDX_W + 1)'(write_en_i) - (IDX_W + 1)'(read_en_i);
        end
    end

    assign head_o  = head_q;
    assign tail_o  = tail_q;
    assign count_o = count_q;

endmodule

//--- src/graduation_list.sv
// Graduation list storage with finished bits, writeback merge
// and the registered commit record of the head entry
`timescale 1ns/1ns

module graduation_list #(
    parameter int NUM_ENTRIES = 16,
    parameter int NUM_WB      = 3
) (
    input  logic                           clk_i,
    input  logic                           rstn_i,
    input  rob_pkg::gl_entry_t             dispatch_i,
    input  rob_pkg::gl_wb_t [NUM_WB-1:0]   wb_i,
    input  logic [NUM_WB-1:0]              wb_en_i,
    input  logic                           flush_i,
    input  logic [$clog2(NUM_ENTRIES)-1:0] flush_idx_i,
    input  logic                           flush_all_i,
    input  logic                           read_head_i,
    input  logic                           stall_i,      // Redirect pending, refuse dispatch
    output logic [$clog2(NUM_ENTRIES)-1:0] alloc_idx_o,
    output logic                           head_ready_o,
    output rob_pkg::commit_t               commit_o,
    output logic                           full_o,
    output logic                           empty_o
);

    import isa_pkg::*;
    import rob_pkg::*;

    localparam int IDX_W = $clog2(NUM_ENTRIES);

    gl_entry_t              entries_q [NUM_ENTRIES];
    logic [NUM_ENTRIES-1:0] valid_q;
    logic [NUM_ENTRIES-1:0] finished_q;
    logic [IDX_W-1:0]       head;
    logic [IDX_W-1:0]       tail;
    logic [IDX_W:0]         count;
    logic [IDX_W-1:0]       wb_idx [NUM_WB];
    logic                   write_en;
    logic                   read_en;

    always_comb begin
        for (int p = 0; p < NUM_WB; p++) begin
            wb_idx[p] = wb_i[p].idx[IDX_W-1:0];
        end
    end

    // No list movement in a flush cycle, the pointers are being rebuilt
    assign write_en = dispatch_i.valid && !full_o && !flush_i && !flush_all_i;
    assign read_en  = read_head_i && head_ready_o && !flush_i && !flush_all_i;

    assign head_ready_o = (count != '0) && valid_q[head] && finished_q[head];
    assign alloc_idx_o  = tail;
    assign full_o       = (count == (IDX_W + 1)'(NUM_ENTRIES - 1)) || stall_i;
    assign empty_o      = (count == '0) && !stall_i;  // Closed, not idle, during a redirect

    // Entry contents, writeback merges result or exception word
    always_ff @(posedge clk_i) begin
        if (write_en) begin
            entries_q[tail] <= dispatch_i;
        end
        for (int p = 0; p < NUM_WB; p++) begin
            if (wb_en_i[p]) begin
                entries_q[wb_idx[p]].exc_valid <= wb_i[p].exc_valid;
                entries_q[wb_idx[p]].payload   <= wb_i[p].payload;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q    <= '0;
            finished_q <= '0;
        end else if (flush_all_i) begin
            valid_q    <= '0;
            finished_q <= '0;
        end else begin
            if (write_en) begin
                valid_q[tail]    <= 1'b1;
                finished_q[tail] <= finishes_at_dispatch(dispatch_i.cls);
            end
            if (read_en) begin
                valid_q[head] <= 1'b0;  // Slot freed at commit
            end
            for (int p = 0; p < NUM_WB; p++) begin
                if (wb_en_i[p]) begin
                    finished_q[wb_idx[p]] <= 1'b1;
                end
            end
        end
    end

    // Commit record is valid for exactly the cycle after the read
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            commit_o <= '0;
        end else begin
            commit_o.valid <= read_en;
            if (read_en) begin
                commit_o.idx       <= 8'(head);
                commit_o.cls       <= entries_q[head].cls;
                commit_o.rd        <= entries_q[head].rd;
                commit_o.pc        <= entries_q[head].pc;
                commit_o.exc_valid <= entries_q[head].exc_valid;
                commit_o.payload   <= entries_q[head].payload;
            end
        end
    end

    gl_pointers #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) i_pointers (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .write_en_i  (write_en),
        .read_en_i   (read_en),
        .flush_i     (flush_i),
        .flush_idx_i (flush_idx_i),
        .flush_all_i (flush_all_i),
        .head_o      (head),
        .tail_o      (tail),
        .count_o     (count)
    );

endmodule

//--- src/isa_pkg.sv
// Instruction classes seen by the completion stage
// and the rule for classes that are finished when dispatched
package isa_pkg;

    // Kinds of instruction tracked in the graduation list
    typedef enum logic [3:0] {
        ALU    = 4'd0,
        MUL    = 4'd1,
        LOAD   = 4'd2,
        STORE  = 4'd3,
        AMO    = 4'd4,
        BRANCH = 4'd5,
        CSR    = 4'd6,
        FENCE  = 4'd7
    } instr_class_e;

    // Stores and fences do their memory work after commit,
    // so nothing writes them back and they are ready at once
    function automatic logic finishes_at_dispatch(instr_class_e cls);
        logic done;
        case (cls)
            STORE:   done = 1'b1;
            FENCE:   done = 1'b1;
            default: done = 1'b0;
        endcase
        return done;
    endfunction

endpackage

//--- src/rob_pkg.sv
// Graduation list records: stored entry, writeback port,
// completion word union and commit record
package rob_pkg;

    typedef logic [3:0] exc_cause_t;

    // Exception reading of the completion word
    typedef struct packed {
        exc_cause_t  cause;
        logic [3:0]  pad;
        logic [23:0] tval;  // Trap value, low bits only
    } gl_exc_word_t;

    // Completion word, read as a result unless exc_valid is set
    typedef union packed {
        logic [31:0]  result;
        gl_exc_word_t exc;
    } gl_payload_u;

    // One entry as dispatched and as stored
    typedef struct packed {
        logic                  valid;
        isa_pkg::instr_class_e cls;
        logic [4:0]            rd;         // Destination register
        logic [31:0]           pc;
        logic                  exc_valid;
        gl_payload_u           payload;
    } gl_entry_t;

    // One writeback port
    typedef struct packed {
        logic [7:0]  idx;                  // Upper bits ignored above the index width
        logic        exc_valid;
        gl_payload_u payload;
    } gl_wb_t;

    // Record of one committed instruction
    typedef struct packed {
        logic                  valid;
        logic [7:0]            idx;
        isa_pkg::instr_class_e cls;
        logic [4:0]            rd;
        logic [31:0]           pc;
        logic                  exc_valid;
        gl_payload_u           payload;
    } commit_t;

endpackage

//--- testbench/commit_assertions.sv
// Bound checker for the completion stage: flags, commit timing,
// flush pulse width and reads during a pending redirect
`timescale 1ns/1ns

module commit_assertions (
    input logic clk_i,
    input logic rstn_i,
    input logic full_i,
    input logic empty_i,
    input logic read_en_i,
    input logic commit_valid_i,
    input logic flush_all_i,
    input logic stall_i         // High while the controller waits for the redirect
);

    assert property (@(posedge clk_i) disable iff (!rstn_i) !(full_i && empty_i))
        else $error("full and empty high together");

    // Commit record follows a read by exactly one cycle
    assert property (@(posedge clk_i) disable iff (!rstn_i) commit_valid_i == $past(read_en_i))
        else $error("commit valid without a read in the previous cycle");

    assert property (@(posedge clk_i) disable iff (!rstn_i) flush_all_i |=> !flush_all_i)
        else $error("flush_all longer than one cycle");

    assert property (@(posedge clk_i) disable iff (!rstn_i) stall_i |-> !read_en_i)
        else $error("read while waiting for the redirect");

endmodule

bind commit_top commit_assertions i_assertions (
    .clk_i          (clk_i),
    .rstn_i         (rstn_i),
    .full_i         (full_o),
    .empty_i        (empty_o),
    .read_en_i      (i_list.read_en),
    .commit_valid_i (commit_o.valid),
    .flush_all_i    (flush_all),
    .stall_i        (stall)
);

//--- testbench/commit_tb.sv
// Testbench for commit_top with random stimulus, a queue reference model,
// compare tasks, watchdog and summary
`timescale 1ns/1ns

module commit_tb;

    import isa_pkg::*;
    import rob_pkg::*;

    localparam int SEED         = 4;
    localparam int DRAIN_LIMIT  = 300;
    localparam int TOTAL_CYCLES = 200 + 200 + 150 + 300 + 300 + 2000;
    localparam longint WATCHDOG_NS = 2 * (TOTAL_CYCLES + 6 * DRAIN_LIMIT + 10) * 20;

    logic              clk_i;
    logic              rstn_i;
    gl_entry_t         dispatch;
    gl_wb_t [2:0]      wb;
    logic [2:0]        wb_en;
    logic              flush;
    logic [3:0]        flush_idx;
    logic              redirect_ack;
    commit_t           commit;
    commit_t           exc;
    logic [3:0]        alloc_idx;
    logic              full;
    logic              empty;

    // Reference model holds indices in program order plus entry contents
    int                model_q [$];
    gl_entry_t         ent [16];
    bit                fin [16];
    logic [3:0]        model_tail;
    bit                waiting;     // Redirect not yet acknowledged
    int                err_count;
    int                commit_count;
    int                exc_count;
    int                disp_pct;
    int                wb_pct;
    int                flush_pct;
    int                exc_pct;
    bit                cls_mode;    // Selects all classes instead of only ALU, MUL and LOAD

    commit_top #(
        .NUM_ENTRIES (16),
        .NUM_WB      (3)
    ) i_dut (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .dispatch_i     (dispatch),
        .alloc_idx_o    (alloc_idx),
        .wb_i           (wb),
        .wb_en_i        (wb_en),
        .flush_i        (flush),
        .flush_idx_i    (flush_idx),
        .commit_o       (commit),
        .exc_o          (exc),
        .redirect_ack_i (redirect_ack),
        .full_o         (full),
        .empty_o        (empty)
    );

    always #10 clk_i = ~clk_i;

    function automatic commit_t ref_commit(input int idx);
        commit_t c;
        c           = '0;
        c.valid     = 1'b1;
        c.idx       = 8'(idx);
        c.cls       = ent[idx].cls;
        c.rd        = ent[idx].rd;
        c.pc        = ent[idx].pc;
        c.exc_valid = ent[idx].exc_valid;
        c.payload   = ent[idx].payload;
        return c;
    endfunction

    task automatic check_commit(input commit_t got, input commit_t exp);
        if (got !== exp) begin
            $display("FAIL @%0t: commit got %h expected %h", $time, got, exp);
            err_count++;
        end
    endtask

    // Exception record is read through the exception view of the payload
    task automatic check_exc(input commit_t got, input commit_t exp);
        if (got.valid !== 1'b1 || got.idx !== exp.idx || got.cls !== exp.cls ||
            got.rd !== exp.rd || got.pc !== exp.pc || got.exc_valid !== 1'b1 ||
            got.payload.exc.cause !== exp.payload.exc.cause ||
            got.payload.exc.tval !== exp.payload.exc.tval) begin
            $display("FAIL @%0t: exc idx %0d cause %h tval %h, want idx %0d cause %h tval %h",
                     $time, got.idx, got.payload.exc.cause, got.payload.exc.tval,
                     exp.idx, exp.payload.exc.cause, exp.payload.exc.tval);
            err_count++;
        end
    endtask

    task automatic compare_flags(input logic got_full, got_empty, exp_full, exp_empty);
        if (got_full !== exp_full || got_empty !== exp_empty) begin
            $display("FAIL @%0t: full/empty got %b%b expected %b%b", $time,
                     got_full, got_empty, exp_full, exp_empty);
            err_count++;
        end
    endtask

    task automatic expect_alloc(input logic [3:0] got, input logic [3:0] exp);
        if (got !== exp) begin
            $display("FAIL @%0t: dispatch index got %0d expected %0d", $time, got, exp);
            err_count++;
        end
    endtask

    task automatic drive_cycle(input bit active);
        gl_entry_t    d;
        gl_wb_t [2:0] w;
        logic [2:0]   en;
        int           n;
        int           start;
        int           pos;
        d     = '0;
        w     = '0;
        en    = '0;
        n     = 0;
        start = $urandom_range(15);
        if (active && ($urandom_range(99) < disp_pct)) begin
            d.valid = 1'b1;
            d.cls   = instr_class_e'(cls_mode ? $urandom_range(7) : $urandom_range(2));
            d.rd    = 5'($urandom);
            d.pc    = $urandom;
        end
        flush <= 1'b0;
        if (active && (model_q.size() != 0) && ($urandom_range(99) < flush_pct)) begin
            flush     <= 1'b1;
            flush_idx <= 4'(model_q[$urandom_range(model_q.size() - 1)]);
        end
        // Each port takes a distinct unfinished entry
        for (int k = 0; k < model_q.size() && n < 3; k++) begin
            pos = model_q[(start + k) % model_q.size()];
            if (!fin[pos] && ($urandom_range(99) < wb_pct)) begin
                w[n].idx            = 8'(pos);
                w[n].exc_valid      = ($urandom_range(99) < exc_pct);
                w[n].payload.result = $urandom;
                en[n]               = 1'b1;
                n++;
            end
        end
        dispatch     <= d;
        wb           <= w;
        wb_en        <= en;
        redirect_ack <= waiting && ($urandom_range(3) == 0);
    endtask

    // Model update and compare on the falling edge where outputs are stable
    always @(negedge clk_i) begin : compare_proc
        commit_t exp;
        bit      take_exc;
        bit      exp_full;
        take_exc = 1'b0;
        if (rstn_i) begin
            if (commit.valid) begin
                if (model_q.size() == 0) begin
                    $display("FAIL @%0t: commit of idx %0d with nothing outstanding",
                             $time, commit.idx);
                    err_count++;
                end else begin
                    exp = ref_commit(model_q.pop_front());
                    check_commit(commit, exp);
                    take_exc = exp.exc_valid;
                    commit_count++;
                end
            end
            exp_full = (model_q.size() == 15) || waiting;
            compare_flags(full, empty, exp_full, (model_q.size() == 0) && !waiting);
            if (take_exc) begin
                check_exc(exc, exp);
                model_q.delete();
                model_tail = '0;
                waiting    = 1'b1;
                exc_count++;
            end else begin
                if (exc.valid) begin
                    $display("FAIL @%0t: exception reported without an excepting commit", $time);
                    err_count++;
                end
                if (flush) begin
                    while (model_q.size() != 0 && model_q[$] != int'(flush_idx)) begin
                        void'(model_q.pop_back());
                    end
                    model_tail = flush_idx + 4'd1;
                end else if (dispatch.valid && !exp_full) begin
                    expect_alloc(alloc_idx, model_tail);
                    ent[model_tail] = dispatch;
                    fin[model_tail] = (dispatch.cls == STORE) || (dispatch.cls == FENCE);
                    model_q.push_back(int'(model_tail));
                    model_tail++;
                end
                if (waiting && redirect_ack) begin
                    waiting = 1'b0;
                end
            end
            for (int p = 0; p < 3; p++) begin
                if (wb_en[p]) begin
                    ent[wb[p].idx[3:0]].exc_valid = wb[p].exc_valid;
                    ent[wb[p].idx[3:0]].payload   = wb[p].payload;
                    fin[wb[p].idx[3:0]]           = 1'b1;
                end
            end
        end
    end

    task automatic run_test(input string name, input int cycles, input int d, input int w,
                            input int f, input int e, input bit mode);
        int errs0;
        int commits0;
        int k;
        errs0     = err_count;
        commits0  = commit_count;
        disp_pct  = d;
        wb_pct    = w;
        flush_pct = f;
        exc_pct   = e;
        cls_mode  = mode;
        repeat (cycles) begin
            @(posedge clk_i);
            drive_cycle(1'b1);
        end
        wb_pct = 100;  // Drain finishes everything still open
        k      = 0;
        do begin
            @(posedge clk_i);
            drive_cycle(1'b0);
            k++;
        end while ((model_q.size() != 0 || waiting) && k < DRAIN_LIMIT);
        if (model_q.size() != 0 || waiting) begin
            $display("Test %s did not drain, %0d entries still outstanding",
                     name, model_q.size());
            err_count++;
        end
        $display("Test %s %s  commits %0d  errors %0d", name,
                 (err_count == errs0) ? "ok" : "FAIL",
                 commit_count - commits0, err_count - errs0);
    endtask

    initial begin
        void'($urandom(SEED));
        clk_i        = 1'b0;
        rstn_i       = 1'b0;
        dispatch     = '0;
        wb           = '0;
        wb_en        = '0;
        flush        = 1'b0;
        flush_idx    = '0;
        redirect_ack = 1'b0;
        model_tail   = '0;
        waiting      = 1'b0;
        err_count    = 0;
        commit_count = 0;
        exc_count    = 0;
        repeat (5) @(posedge clk_i);
        rstn_i <= 1'b1;
        run_test("in_order", 200, 60, 40, 0, 0, 1'b0);
        run_test("store_fence", 200, 60, 20, 0, 0, 1'b1);
        run_test("capacity", 150, 100, 3, 0, 0, 1'b0);
        run_test("partial_flush", 300, 60, 30, 8, 0, 1'b1);
        run_test("exception", 300, 60, 30, 0, 10, 1'b1);
        run_test("random_mix", 2000, 50, 35, 3, 3, 1'b1);
        $display("Summary: %0d commits, %0d exceptions, %0d errors",
                 commit_count, exc_count, err_count);
        if (err_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired, the tests did not finish in time");
        $display("Result: FAILED");
        $finish;
    end

endmodule
